// File: Makefile
# Verilator build and run for the memory bus testbench

VERILATOR ?= verilator
TOP ?= tb_memory_bus
FILELIST ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST)) include/bus_config.svh
BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

# Fails unless the pass line appears in the simulation output
run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Done: no errors"

clean:
	rm -rf $(BUILD_DIR)

// File: include/bus_config.svh
////////////////////////////////////////////////////////////////////////////
// Memory bus configuration
// Data width, bank geometry and wait-state spacing shared by the fabric
////////////////////////////////////////////////////////////////////////////

`ifndef BUS_CONFIG_SVH
`define BUS_CONFIG_SVH

// Width of a data word on every path
`define BUS_DATA_W 32

// Number of banks, one per mapped region
`define BANK_COUNT 4

// Words per bank and the matching offset width
`define BANK_WORDS 256
`define BANK_OFFSET_W 8

// Extra wait cycles added per bank index
// Bank i answers after i times this many waits
`define BANK_WAIT_STEP 2

`endif

// File: project.f
+incdir+include
source/bus_pkg.sv
source/bus_ifs.sv
source/bus_bridge.sv
source/address_decoder.sv
source/mem_bank.sv
source/response_merger.sv
source/memory_bus.sv
test/tb_memory_bus.sv

// File: source/address_decoder.sv
////////////////////////////////////////////////////////////////////////////
// Address decoder
// Routes the held access to one bank by region, and raises an error
// strobe for unmapped or misaligned addresses
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "bus_config.svh"

module address_decoder
	import bus_pkg::*;
(
	host_bus_if.decode host,
	bank_if.decoder bank [`BANK_COUNT],
	output logic o_err_strobe,
	input logic i_clock,
	input logic i_arst_n
);

	region_t region;
	logic mapped;
	logic aligned;
	logic access_ok;
	logic [`BANK_COUNT-1:0] en_vec;

	assign region = host.address.fields.region;
	assign mapped = region < region_t'(`BANK_COUNT);
	assign aligned = host.address.fields.byte_sel == 2'b00;
	assign access_ok = mapped && aligned;

	// Region n selects bank n
	for (genvar i = 0; i < `BANK_COUNT; i++) begin : g_route
		assign en_vec[i] = host.active && access_ok && (region == region_t'(i));
		assign bank[i].enable = en_vec[i];
		assign bank[i].rw = host.rw;
		assign bank[i].offset = host.address.fields.offset;
		assign bank[i].wdata = host.wdata;
	end

	// One-cycle strobe an edge after active rises
	// Cleared by its own feedback while active is still high
	always_ff @(posedge i_clock or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_err_strobe <= 1'b0;
		end else begin
			o_err_strobe <= host.active && !access_ok && !o_err_strobe;
		end
	end

	// Bank choice holds for the whole transaction
	assert property (@(posedge i_clock) disable iff (!i_arst_n)
		host.active && $past(host.active) |-> $stable(en_vec))
		else $error("decoder: bank selection changed during a transaction");

endmodule

`default_nettype wire

// File: source/bus_bridge.sv
////////////////////////////////////////////////////////////////////////////
// Requester bridge
// Latches one access, holds it on the internal bus until a response
// arrives, then returns registered data, ready and error
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "bus_config.svh"

module bus_bridge
	import bus_pkg::*;
(
	input logic i_clock,
	input logic i_arst_n,
	input logic i_request,
	input logic i_rw,
	input logic [31:0] i_address,
	input logic [`BUS_DATA_W-1:0] i_wdata,
	output logic [`BUS_DATA_W-1:0] o_rdata,
	output logic o_ready,
	output logic o_error,
	host_bus_if.bridge host
);

	// Idle when low, busy while a transaction is open
	logic busy;
	logic start;

	logic held_rw;
	addr_word_u held_addr;
	logic [`BUS_DATA_W-1:0] held_wdata;

	assign start = !busy && i_request;

	always_ff @(posedge i_clock or negedge i_arst_n) begin
		if (!i_arst_n) begin
			busy <= 1'b0;
			o_ready <= 1'b0;
			o_error <= 1'b0;
			o_rdata <= '0;
		end else begin
			o_ready <= 1'b0;
			o_error <= 1'b0;
			if (!busy) begin
				busy <= i_request;
			end else if (host.ready) begin
				busy <= 1'b0;
				o_ready <= 1'b1;
				o_error <= host.error;
				// Writes and failed accesses return zero
				o_rdata <= (held_rw || host.error) ? '0 : host.rdata;
			end
		end
	end

	// Request payload, stable for the whole transaction
	always_ff @(posedge i_clock) begin
		if (start) begin
			held_rw <= i_rw;
			held_addr.word <= i_address;
			held_wdata <= i_wdata;
		end
	end

	assign host.active = busy;
	assign host.rw = held_rw;
	assign host.address = held_addr;
	assign host.wdata = held_wdata;

	// No response may arrive without an open transaction
	assert property (@(posedge i_clock) disable iff (!i_arst_n) host.ready |-> busy)
		else $error("bridge: response seen while idle");

endmodule

`default_nettype wire

// File: source/bus_ifs.sv
////////////////////////////////////////////////////////////////////////////
// Internal bus interfaces
// host_bus_if links the bridge to decode and response logic,
// bank_if links the decoder and merger to each memory bank
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "bus_config.svh"

interface host_bus_if
	import bus_pkg::*;
();

	// Request held while a transaction is open
	logic active;
	logic rw;
	addr_word_u address;
	logic [`BUS_DATA_W-1:0] wdata;

	// Merged response with a single-cycle ready
	logic [`BUS_DATA_W-1:0] rdata;
	logic ready;
	logic error;

	modport bridge (output active, rw, address, wdata, input rdata, ready, error);
	modport decode (input active, rw, address, wdata);
	modport respond (output rdata, ready, error);

endinterface

interface bank_if
	import bus_pkg::*;
();

	logic enable;
	logic rw;
	offset_t offset;
	logic [`BUS_DATA_W-1:0] wdata;
	logic [`BUS_DATA_W-1:0] rdata;
	logic ready;

	modport decoder (output enable, rw, offset, wdata, input rdata, ready);
	modport bank (input enable, rw, offset, wdata, output rdata, ready);
	modport monitor (input rdata, ready);

endinterface

`default_nettype wire

// File: source/bus_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Memory bus types
// Address word with its region and offset views
////////////////////////////////////////////////////////////////////////////

`default_nettype none

`include "bus_config.svh"

package bus_pkg;

	// Region number from the top address nibble
	typedef logic [3:0] region_t;

	// Word index inside one bank
	typedef logic [`BANK_OFFSET_W-1:0] offset_t;

	// Field view of a byte address
	typedef struct packed {
		region_t region;
		logic [32-4-`BANK_OFFSET_W-2-1:0] unused;
		offset_t offset;
		logic [1:0] byte_sel;
	} addr_fields_t;

	typedef union packed {
		logic [31:0] word;
		addr_fields_t fields;
	} addr_word_u;

endpackage

`default_nettype wire

// File: source/mem_bank.sv
////////////////////////////////////////////////////////////////////////////
// Memory bank
// Word RAM that answers after WAIT_CYCLES extra edges with a
// single-cycle ready pulse
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "bus_config.svh"

module mem_bank #(
	parameter int WAIT_CYCLES = 0
) (
	input logic i_clock,
	input logic i_arst_n,
	bank_if.bank port
);

	localparam int CNT_W = $clog2(WAIT_CYCLES + 2);

	logic [`BUS_DATA_W-1:0] mem [`BANK_WORDS];
	logic [`BUS_DATA_W-1:0] rdata_q;
	logic [CNT_W-1:0] wait_cnt;
	logic ready_q;
	logic blocked;
	logic fire;

	// Access completes on the edge where the count reaches the wait target
	assign fire = port.enable && !blocked && (wait_cnt == CNT_W'(WAIT_CYCLES));

	always_ff @(posedge i_clock or negedge i_arst_n) begin
		if (!i_arst_n) begin
			ready_q <= 1'b0;
			blocked <= 1'b0;
			wait_cnt <= '0;
		end else begin
			ready_q <= fire;
			// Stay parked after the pulse until enable goes low
			if (!port.enable) begin
				blocked <= 1'b0;
			end else if (fire) begin
				blocked <= 1'b1;
			end
			if (fire || !port.enable) begin
				wait_cnt <= '0;
			end else if (!blocked) begin
				wait_cnt <= wait_cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge i_clock) begin
		if (fire) begin
			if (port.rw) begin
				mem[port.offset] <= port.wdata;
			end else begin
				rdata_q <= mem[port.offset];
			end
		end
	end

	assign port.ready = ready_q;
	assign port.rdata = rdata_q;

	assert property (@(posedge i_clock) disable iff (!i_arst_n) port.ready |-> port.enable)
		else $error("bank: ready without enable");

endmodule

`default_nettype wire

// File: source/memory_bus.sv
////////////////////////////////////////////////////////////////////////////
// Memory bus top level
// Bridge, region decoder, four wait-state banks and response merger
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "bus_config.svh"

module memory_bus (
	input logic i_clock,
	input logic i_arst_n,
	input logic i_request,
	input logic i_rw,
	input logic [31:0] i_address,
	input logic [`BUS_DATA_W-1:0] i_wdata,
	output logic [`BUS_DATA_W-1:0] o_rdata,
	output logic o_ready,
	output logic o_error
);

	host_bus_if host_bus ();
	bank_if bank_bus [`BANK_COUNT] ();

	logic err_strobe;

	bus_bridge bridge_inst (
		.i_clock(i_clock),
		.i_arst_n(i_arst_n),
		.i_request(i_request),
		.i_rw(i_rw),
		.i_address(i_address),
		.i_wdata(i_wdata),
		.o_rdata(o_rdata),
		.o_ready(o_ready),
		.o_error(o_error),
		.host(host_bus)
	);

	address_decoder decoder_inst (
		.host(host_bus),
		.bank(bank_bus),
		.o_err_strobe(err_strobe),
		.i_clock(i_clock),
		.i_arst_n(i_arst_n)
	);

	// Bank 0 is zero-wait, later banks are slower
	for (genvar i = 0; i < `BANK_COUNT; i++) begin : g_bank
		mem_bank #(
			.WAIT_CYCLES(i * `BANK_WAIT_STEP)
		) bank_inst (
			.i_clock(i_clock),
			.i_arst_n(i_arst_n),
			.port(bank_bus[i])
		);
	end

	response_merger merger_inst (
		.bank(bank_bus),
		.i_err_strobe(err_strobe),
		.host(host_bus)
	);

endmodule

`default_nettype wire

// File: source/response_merger.sv
////////////////////////////////////////////////////////////////////////////
// Response merger
// Combines bank ready pulses and the decode error strobe into one
// response toward the bridge
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "bus_config.svh"

module response_merger (
	bank_if.monitor bank [`BANK_COUNT],
	input logic i_err_strobe,
	host_bus_if.respond host
);

	logic [`BANK_COUNT-1:0] ready_vec;
	logic [`BUS_DATA_W-1:0] rdata_vec [`BANK_COUNT];
	logic [`BUS_DATA_W-1:0] rdata_sel;

	for (genvar i = 0; i < `BANK_COUNT; i++) begin : g_collect
		assign ready_vec[i] = bank[i].ready;
		assign rdata_vec[i] = bank[i].rdata;
	end

	// Data of whichever bank is answering, zero otherwise
	always_comb begin
		rdata_sel = '0;
		for (int k = 0; k < `BANK_COUNT; k++) begin
			if (ready_vec[k]) begin
				rdata_sel = rdata_vec[k];
			end
		end
	end

	assign host.rdata = rdata_sel;
	assign host.ready = (|ready_vec) || i_err_strobe;
	assign host.error = i_err_strobe;

	// Only one transaction is open, so only one source may answer
	always_comb begin
		assert final ($onehot0({ready_vec, i_err_strobe}))
			else $error("merger: several response sources active");
	end

endmodule

`default_nettype wire

// File: test/tb_memory_bus.sv
////////////////////////////////////////////////////////////////////////////
// Memory bus testbench
// Table-driven and random accesses checked against a shadow memory,
// with latency and error checks per access
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "bus_config.svh"

module tb_memory_bus;

	localparam int CLK_PERIOD = 4;
	localparam int RESET_CYCLES = 5;
	localparam int IDLE_CYCLES = 4;
	localparam int RANDOM_COUNT = 200;
	localparam int CYCLES_PER_ACCESS = 20;

	typedef struct packed {
		logic wr;
		logic [31:0] addr;
		logic [31:0] wdata;
		logic [31:0] exp_rdata;
		logic exp_err;
		logic [7:0] exp_lat;
	} entry_t;

	logic clock;
	logic arst_n;
	logic request;
	logic rw;
	logic [31:0] address;
	logic [31:0] wdata;
	logic [31:0] rdata;
	logic ready;
	logic error;

	entry_t table_q [$];
	logic [31:0] shadow [0:`BANK_COUNT-1][0:`BANK_WORDS-1];
	bit written [0:`BANK_COUNT-1][0:`BANK_WORDS-1];
	int checks;
	int errors;

	memory_bus memory_bus_inst (
		.i_clock(clock),
		.i_arst_n(arst_n),
		.i_request(request),
		.i_rw(rw),
		.i_address(address),
		.i_wdata(wdata),
		.o_rdata(rdata),
		.o_ready(ready),
		.o_error(error)
	);

	initial begin
		clock = 1'b0;
		forever #(CLK_PERIOD / 2) clock = ~clock;
	end

	task automatic check_value(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("error at %0t: %s: got 0x%08h, expected 0x%08h", $time, what, got, exp);
		end
	endtask

	// Mapped region and word-aligned byte address
	function automatic logic access_valid(input logic [31:0] addr);
		return (addr[31:28] < 4'(`BANK_COUNT)) && (addr[1:0] == 2'b00);
	endfunction

	// Bank i takes i wait steps plus two edges, errors take two
	function automatic int expected_latency(input logic [31:0] addr);
		if (access_valid(addr)) begin
			return int'(addr[31:28]) * `BANK_WAIT_STEP + 2;
		end
		return 2;
	endfunction

	task automatic add_entry(input logic wr, input logic [31:0] addr, input logic [31:0] wd,
		input logic [31:0] exp_rd, input logic exp_err, input int lat);
		entry_t e;
		e.wr = wr;
		e.addr = addr;
		e.wdata = wd;
		e.exp_rdata = exp_rd;
		e.exp_err = exp_err;
		e.exp_lat = 8'(lat);
		table_q.push_back(e);
	endtask

	task automatic build_table();
		// Write then read offset 0x10 of every bank
		add_entry(1'b1, 32'h0000_0040, 32'h1111_0040, 32'h0, 1'b0, 2);
		add_entry(1'b0, 32'h0000_0040, 32'h0, 32'h1111_0040, 1'b0, 2);
		add_entry(1'b1, 32'h1000_0040, 32'h2222_0040, 32'h0, 1'b0, 4);
		add_entry(1'b0, 32'h1000_0040, 32'h0, 32'h2222_0040, 1'b0, 4);
		add_entry(1'b1, 32'h2000_0040, 32'h3333_0040, 32'h0, 1'b0, 6);
		add_entry(1'b0, 32'h2000_0040, 32'h0, 32'h3333_0040, 1'b0, 6);
		add_entry(1'b1, 32'h3000_0040, 32'h4444_0040, 32'h0, 1'b0, 8);
		add_entry(1'b0, 32'h3000_0040, 32'h0, 32'h4444_0040, 1'b0, 8);
		// Unmapped write must leave every bank untouched
		add_entry(1'b1, 32'h4000_0040, 32'hdead_beef, 32'h0, 1'b1, 2);
		add_entry(1'b0, 32'h0000_0040, 32'h0, 32'h1111_0040, 1'b0, 2);
		add_entry(1'b0, 32'h1000_0040, 32'h0, 32'h2222_0040, 1'b0, 4);
		add_entry(1'b0, 32'h2000_0040, 32'h0, 32'h3333_0040, 1'b0, 6);
		add_entry(1'b0, 32'h3000_0040, 32'h0, 32'h4444_0040, 1'b0, 8);
		add_entry(1'b0, 32'h8000_0040, 32'h0, 32'h0, 1'b1, 2);
		add_entry(1'b1, 32'hf000_0040, 32'h0bad_0bad, 32'h0, 1'b1, 2);
		add_entry(1'b0, 32'h5000_0000, 32'h0, 32'h0, 1'b1, 2);
		// Misaligned accesses
		add_entry(1'b0, 32'h0000_0041, 32'h0, 32'h0, 1'b1, 2);
		add_entry(1'b1, 32'h1000_0042, 32'h5555_5555, 32'h0, 1'b1, 2);
		add_entry(1'b0, 32'h2000_0043, 32'h0, 32'h0, 1'b1, 2);
		add_entry(1'b0, 32'h1000_0040, 32'h0, 32'h2222_0040, 1'b0, 4);
		// Top word of the slowest bank
		add_entry(1'b1, 32'h3000_03fc, 32'h6666_03fc, 32'h0, 1'b0, 8);
		add_entry(1'b0, 32'h3000_03fc, 32'h0, 32'h6666_03fc, 1'b0, 8);
	endtask

	// Starts and ends on a falling edge with the request low
	task automatic run_access(input logic wr, input logic [31:0] addr, input logic [31:0] wd,
		input logic [31:0] exp_rd, input logic exp_err, input int exp_lat, input string tag);
		int edges;
		request = 1'b1;
		rw = wr;
		address = addr;
		wdata = wd;
		// Edge 0 latches the request
		@(negedge clock);
		edges = 0;
		while (!ready) begin
			@(negedge clock);
			edges++;
		end
		request = 1'b0;
		rw = 1'b0;
		check_value($sformatf("%s rdata", tag), rdata, exp_rd);
		check_value($sformatf("%s error", tag), 32'(error), 32'(exp_err));
		check_value($sformatf("%s latency", tag), edges, exp_lat);
		if (wr && access_valid(addr)) begin
			shadow[addr[29:28]][addr[9:2]] = wd;
			written[addr[29:28]][addr[9:2]] = 1'b1;
		end
		@(negedge clock);
		check_value($sformatf("%s ready width", tag), 32'(ready), 32'h0);
	endtask

	// Runs the whole test length plus reset before giving up
	initial begin
		int limit;
		#1;
		limit = RESET_CYCLES + IDLE_CYCLES + 2;
		limit += (table_q.size() + RANDOM_COUNT) * CYCLES_PER_ACCESS;
		repeat (limit) @(posedge clock);
		$display("watchdog: a transaction never completed within %0d cycles", limit);
		$display("Done: errors found");
		$finish;
	end

	initial begin
		logic wr;
		logic [3:0] region;
		logic [7:0] offset;
		logic [1:0] bsel;
		logic [31:0] addr;
		logic [31:0] wd;
		logic [31:0] exp_rd;
		logic ok;
		void'($urandom(32'hcbad95f5));
		checks = 0;
		errors = 0;
		arst_n = 1'b0;
		request = 1'b0;
		rw = 1'b0;
		address = 32'h0;
		wdata = 32'h0;
		build_table();

		repeat (RESET_CYCLES) @(negedge clock);
		arst_n = 1'b1;

		// Quiet bus after reset
		repeat (IDLE_CYCLES) begin
			@(negedge clock);
			check_value("idle ready", 32'(ready), 32'h0);
			check_value("idle error", 32'(error), 32'h0);
		end

		foreach (table_q[n]) begin
			run_access(table_q[n].wr, table_q[n].addr, table_q[n].wdata,
				table_q[n].exp_rdata, table_q[n].exp_err, int'(table_q[n].exp_lat),
				$sformatf("entry %0d", n));
		end

		for (int n = 0; n < RANDOM_COUNT; n++) begin
			if ($urandom_range(3, 0) != 0) begin
				region = 4'($urandom_range(3, 0));
			end else begin
				region = 4'($urandom_range(15, 4));
			end
			if ($urandom_range(7, 0) == 0) begin
				bsel = 2'($urandom_range(3, 1));
			end else begin
				bsel = 2'b00;
			end
			// Small offset range so reads often hit written words
			offset = 8'($urandom_range(15, 0));
			addr = {region, 18'($urandom), offset, bsel};
			wd = $urandom;
			wr = 1'($urandom_range(1, 0));
			ok = access_valid(addr);
			// Never read a word the shadow has no value for
			if (ok && !wr && !written[region[1:0]][offset]) begin
				wr = 1'b1;
			end
			exp_rd = 32'h0;
			if (ok && !wr) begin
				exp_rd = shadow[region[1:0]][offset];
			end
			run_access(wr, addr, wd, exp_rd, !ok, expected_latency(addr),
				$sformatf("random %0d @0x%08h", n, addr));
		end

		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire
